// File: design/motorPwmCtrl.sv
`timescale 1ns/100ps

module motorPwmCtrl import motorPwmPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic [MODE_W-1:0] dutyMode,
    output logic [CNT_W-1:0]  baseDuty,
    output logic              rampActive,
    output logic              rampUp,
    output logic              fullOn,
    output logic              rampRestart
);

    logic [MODE_W-1:0] modeReg;                     // mode currently in force

    function automatic logic isRampMode(input logic [MODE_W-1:0] mode);
        return (mode == MODE_RAMP_FORTY) || (mode == MODE_RAMP_EIGHTY);
    endfunction

    // ----------------------------------------
    // mode register and ramp restart
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            modeReg     <= MODE_STATIC_FORTY;
            rampRestart <= 1'b0;
        end else begin
            modeReg     <= dutyMode;
            // entering a ramp from any other mode, even the other ramp, starts over
            rampRestart <= isRampMode(dutyMode) && (dutyMode != modeReg);
        end
    end

    // ----------------------------------------
    // decode
    // ----------------------------------------
    always_comb begin
        baseDuty   = CNT_W'(DUTY_FORTY);
        rampActive = 1'b0;
        rampUp     = 1'b0;
        fullOn     = 1'b0;
        case (modeReg)
            MODE_STATIC_FORTY: begin
                baseDuty = CNT_W'(DUTY_FORTY);
            end
            MODE_RAMP_FORTY: begin
                baseDuty   = CNT_W'(DUTY_FORTY);
                rampActive = 1'b1;                  // overdrive takes duty down
            end
            MODE_RAMP_EIGHTY: begin
                baseDuty   = CNT_W'(DUTY_EIGHTY);
                rampActive = 1'b1;
                rampUp     = 1'b1;                  // overdrive takes duty up
            end
            MODE_FULL: begin
                baseDuty = CNT_W'(PWM_PERIOD);
                fullOn   = 1'b1;
            end
            default: begin
                baseDuty = CNT_W'(DUTY_FORTY);
            end
        endcase
    end

endmodule

// File: design/motorPwmPkg.sv
package motorPwmPkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int CNT_W   = 8;                     // frame count and duty thresholds
    localparam int LEVEL_W = 2;                     // overdrive level
    localparam int MODE_W  = 2;                     // requested drive mode

    // ----------------------------------------
    // frame and duty constants
    // ----------------------------------------
    // scaled down for simulation, the hardware frame is 12500 cycles
    localparam int PWM_PERIOD  = 125;               // cycles per pwm frame
    localparam int DUTY_FORTY  = 50;                // high cycles at 40 %
    localparam int DUTY_EIGHTY = 100;               // high cycles at 80 %
    localparam int DUTY_STEP   = 6;                 // roughly 5 % of the frame per level

    // ----------------------------------------
    // ramp timing
    // ----------------------------------------
    localparam int STEP_PERIODS = 4;                // frames between level increments
    localparam int TALLY_W      = $clog2(STEP_PERIODS);
    localparam int LEVEL_MAX    = 3;                // level saturates here

    // ----------------------------------------
    // mode codes
    // ----------------------------------------
    localparam logic [MODE_W-1:0] MODE_STATIC_FORTY = 2'd0;
    localparam logic [MODE_W-1:0] MODE_RAMP_FORTY   = 2'd1;  // steps down while held
    localparam logic [MODE_W-1:0] MODE_RAMP_EIGHTY  = 2'd2;  // steps up while held
    localparam logic [MODE_W-1:0] MODE_FULL         = 2'd3;

endpackage

// File: design/motorPwmTop.sv
`timescale 1ns/100ps

module motorPwmTop import motorPwmPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic [MODE_W-1:0] dutyMode,
    output logic              pulseOut,
    output logic              periodSync
);

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    logic [CNT_W-1:0]   frameCount;
    logic               periodStart;
    logic               periodEnd;
    logic [CNT_W-1:0]   baseDuty;
    logic               rampActive;
    logic               rampUp;
    logic               fullOn;
    logic               rampRestart;
    logic [LEVEL_W-1:0] rampLevel;

    assign periodSync = periodStart;                // sampling strobe for the motor side

    // ----------------------------------------
    // instances
    // ----------------------------------------
    motorPwmCtrl i_ctrl (
        .clk         (clk),
        .rstN        (rstN),
        .dutyMode    (dutyMode),
        .baseDuty    (baseDuty),
        .rampActive  (rampActive),
        .rampUp      (rampUp),
        .fullOn      (fullOn),
        .rampRestart (rampRestart)
    );

    periodCounter i_periodCounter (
        .clk         (clk),
        .rstN        (rstN),
        .frameCount  (frameCount),
        .periodStart (periodStart),
        .periodEnd   (periodEnd)
    );

    rampTimer i_rampTimer (
        .clk         (clk),
        .rstN        (rstN),
        .periodEnd   (periodEnd),
        .rampRestart (rampRestart),
        .rampLevel   (rampLevel)
    );

    pwmOutput i_pwmOutput (
        .clk         (clk),
        .rstN        (rstN),
        .frameCount  (frameCount),
        .periodStart (periodStart),
        .baseDuty    (baseDuty),
        .rampActive  (rampActive),
        .rampUp      (rampUp),
        .fullOn      (fullOn),
        .rampLevel   (rampLevel),
        .pulseOut    (pulseOut)
    );

endmodule

// File: design/periodCounter.sv
`timescale 1ns/100ps

module periodCounter import motorPwmPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    output logic [CNT_W-1:0] frameCount,
    output logic             periodStart,
    output logic             periodEnd
);

    logic lastCount;                                // frame wraps at the next edge

    assign lastCount = (frameCount == CNT_W'(PWM_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            frameCount <= '0;
        end else if (lastCount) begin
            frameCount <= '0;
        end else begin
            frameCount <= frameCount + 1'b1;
        end
    end

    // strobes are registered one count early so they line up with the frame
    always_ff @(posedge clk) begin
        if (!rstN) begin
            periodStart <= 1'b0;
            periodEnd   <= 1'b0;
        end else begin
            periodStart <= lastCount;               // high while count is 0
            periodEnd   <= (frameCount == CNT_W'(PWM_PERIOD - 2));  // high at the last count
        end
    end

endmodule

// File: design/pwmOutput.sv
`timescale 1ns/100ps

module pwmOutput import motorPwmPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic [CNT_W-1:0]   frameCount,
    input  logic               periodStart,
    input  logic [CNT_W-1:0]   baseDuty,
    input  logic               rampActive,
    input  logic               rampUp,
    input  logic               fullOn,
    input  logic [LEVEL_W-1:0] rampLevel,
    output logic               pulseOut
);

    logic [CNT_W-1:0] stepAmount;                   // overdrive offset for the current level
    logic [CNT_W-1:0] nextThreshold;
    logic [CNT_W-1:0] heldThreshold;                // threshold in force for this frame
    logic [CNT_W-1:0] activeThreshold;

    // ----------------------------------------
    // threshold selection
    // ----------------------------------------
    assign stepAmount = CNT_W'(rampLevel) * CNT_W'(DUTY_STEP);

    always_comb begin
        if (fullOn) begin
            nextThreshold = CNT_W'(PWM_PERIOD);     // count never reaches this, so always high
        end else if (rampActive && rampUp) begin
            nextThreshold = baseDuty + stepAmount;
        end else if (rampActive) begin
            nextThreshold = baseDuty - stepAmount;
        end else begin
            nextThreshold = baseDuty;
        end
    end

    // ----------------------------------------
    // latch at frame start
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            heldThreshold <= '0;                    // first frame after reset stays low
        end else if (periodStart) begin
            heldThreshold <= nextThreshold;
        end
    end

    // on the start cycle the register still holds last frame's value,
    // so count 0 compares against the new threshold directly
    assign activeThreshold = periodStart ? nextThreshold : heldThreshold;

    // ----------------------------------------
    // pulse register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pulseOut <= 1'b0;
        end else begin
            pulseOut <= (frameCount < activeThreshold);  // one cycle behind the frame
        end
    end

endmodule

// File: design/rampTimer.sv
`timescale 1ns/100ps

module rampTimer import motorPwmPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               periodEnd,
    input  logic               rampRestart,
    output logic [LEVEL_W-1:0] rampLevel
);

    logic [TALLY_W-1:0] periodTally;                // frames since the last level step
    logic               tallyFull;
    logic               levelAtMax;

    assign tallyFull  = (periodTally == TALLY_W'(STEP_PERIODS - 1));
    assign levelAtMax = (rampLevel == LEVEL_W'(LEVEL_MAX));

    // ----------------------------------------
    // period tally
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            periodTally <= '0;
        end else if (rampRestart) begin
            periodTally <= '0;                      // restart wins over a coinciding frame end
        end else if (periodEnd) begin
            if (tallyFull) begin
                periodTally <= '0;
            end else begin
                periodTally <= periodTally + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // overdrive level
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rampLevel <= '0;
        end else if (rampRestart) begin
            rampLevel <= '0;
        end else if (periodEnd && tallyFull && !levelAtMax) begin
            // the tally keeps running at the top, only the level holds
            rampLevel <= rampLevel + 1'b1;
        end
    end

endmodule

// File: sim.f
design/motorPwmPkg.sv
design/motorPwmCtrl.sv
design/periodCounter.sv
design/rampTimer.sv
design/pwmOutput.sv
design/motorPwmTop.sv
verification/motorPwmAssert.sv
verification/motorPwmTb.sv

// File: verification/motorPwmAssert.sv
`timescale 1ns/100ps

module motorPwmAssert (
    input logic clk,
    input logic rstN,
    input logic periodStart,
    input logic periodEnd,
    input logic pulseOut
);

    // ----------------------------------------
    // frame strobes
    // ----------------------------------------
    endThenStart: assert property (
        @(posedge clk) disable iff (!rstN) periodEnd |=> periodStart
    ) else $error("periodStart did not follow periodEnd by one cycle");

    strobesApart: assert property (
        @(posedge clk) disable iff (!rstN) !(periodStart && periodEnd)
    ) else $error("periodStart and periodEnd were high in the same cycle");

    startSingleCycle: assert property (
        @(posedge clk) disable iff (!rstN) periodStart |=> !periodStart
    ) else $error("periodStart stayed high for more than one cycle");

    // ----------------------------------------
    // pulse after reset
    // ----------------------------------------
    // the threshold is still zero, so the first cycles out of reset stay low
    lowAfterReset: assert property (
        @(posedge clk) $rose(rstN) |-> !pulseOut ##1 !pulseOut
    ) else $error("pulseOut went high in the cycle after reset release");

endmodule

// strobe checks on the frame counter
bind periodCounter motorPwmAssert i_strobeAssert (
    .clk         (clk),
    .rstN        (rstN),
    .periodStart (periodStart),
    .periodEnd   (periodEnd),
    .pulseOut    (1'b0)
);

// pulse check on the output stage, it has no end strobe
bind pwmOutput motorPwmAssert i_pulseAssert (
    .clk         (clk),
    .rstN        (rstN),
    .periodStart (periodStart),
    .periodEnd   (1'b0),
    .pulseOut    (pulseOut)
);

// File: verification/motorPwmTb.sv
`timescale 1ns/100ps

module motorPwmTb import motorPwmPkg::*; ();

    // ----------------------------------------
    // signals and bookkeeping
    // ----------------------------------------
    localparam int SYNC_TIMEOUT = 3 * PWM_PERIOD;   // longest allowed wait for a frame strobe
    localparam int LINE_CHARS   = 120;

    logic              clk;
    logic              rstN;
    logic [MODE_W-1:0] dutyMode;
    logic              pulseOut;
    logic              periodSync;

    int mismatchCount;
    int timeoutCount;
    int otherCount;
    int linesChecked;
    bit timedOut;                                   // stops the run after a lost strobe
    logic [CNT_W-1:0] frameExpected;                // high count of the frame last checked

    motorPwmTop i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .dutyMode   (dutyMode),
        .pulseOut   (pulseOut),
        .periodSync (periodSync)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic checkHighCount(input int lineNo, input logic [CNT_W-1:0] actual,
                                  input logic [CNT_W-1:0] expected);
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch pulseOut high count (data line %0d): actual 0x%0h, expected 0x%0h",
                     lineNo, actual, expected);
        end
    endtask

    task automatic checkPeriodLength(input int lineNo, input logic [CNT_W-1:0] actual,
                                     input logic [CNT_W-1:0] expected);
        if (actual !== expected) begin
            mismatchCount++;
            $display("Mismatch periodSync spacing (data line %0d): actual 0x%0h, expected 0x%0h",
                     lineNo, actual, expected);
        end
    endtask

    // ----------------------------------------
    // frame helpers
    // ----------------------------------------
    // leaves the caller at the falling edge inside the strobe cycle
    task automatic waitForSync(output logic [CNT_W-1:0] spacing);
        int waited;
        bit found;
        waited = 0;
        found  = 1'b0;
        while (!found && waited < SYNC_TIMEOUT) begin
            @(negedge clk);
            waited++;
            found = periodSync;
        end
        if (!found) begin
            timeoutCount++;
            timedOut = 1'b1;
            $display("Timeout: periodSync did not arrive within %0d cycles", SYNC_TIMEOUT);
        end
        spacing = CNT_W'(waited);
    endtask

    // pulse lags the frame by one cycle, so the window runs up to the next strobe
    task automatic measureFrame(output logic [CNT_W-1:0] highCount,
                                output logic [CNT_W-1:0] syncPos);
        int highs;
        int pos;
        highs = 0;
        pos   = 0;
        for (int i = 1; i <= PWM_PERIOD; i++) begin
            @(negedge clk);
            if (pulseOut) begin
                highs++;
            end
            if (periodSync && pos == 0) begin
                pos = i;                            // should land on the last cycle
            end
        end
        highCount = CNT_W'(highs);
        syncPos   = CNT_W'(pos);
    endtask

    task automatic applyMode(input logic [MODE_W-1:0] mode);
        @(posedge clk);
        dutyMode <= mode;
    endtask

    // the frame in flight keeps its old threshold and the applied mode shows on the next one
    task automatic runLine(input int lineNo, input logic [MODE_W-1:0] mode, input bit apply,
                           input logic [CNT_W-1:0] expected);
        logic [CNT_W-1:0] highCount;
        logic [CNT_W-1:0] syncPos;
        if (apply) begin
            applyMode(mode);
            measureFrame(highCount, syncPos);
            checkHighCount(lineNo, highCount, frameExpected);
            checkPeriodLength(lineNo, syncPos, CNT_W'(PWM_PERIOD));
        end
        measureFrame(highCount, syncPos);
        checkHighCount(lineNo, highCount, expected);
        checkPeriodLength(lineNo, syncPos, CNT_W'(PWM_PERIOD));
        linesChecked++;
        frameExpected = expected;
    endtask

    // ----------------------------------------
    // data file parsing
    // ----------------------------------------
    function automatic bit isCommentOrBlank(input logic [8*LINE_CHARS-1:0] text);
        logic [7:0] ch;
        for (int i = LINE_CHARS - 1; i >= 0; i--) begin
            ch = text[8*i +: 8];
            if (ch == "#") begin
                return 1'b1;
            end
            if (ch != 8'h00 && ch != " " && ch != "\t" && ch != "\n" && ch != "\r") begin
                return 1'b0;                        // first real character is data
            end
        end
        return 1'b1;
    endfunction

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int                     fd;
        int                     lineNo;
        int                     fields;
        int                     lineMode;
        int                     lineApply;
        int                     lineExpected;
        logic [8*LINE_CHARS-1:0] lineText;
        logic [CNT_W-1:0]       spacing;

        mismatchCount = 0;
        timeoutCount  = 0;
        otherCount    = 0;
        linesChecked  = 0;
        timedOut      = 1'b0;
        frameExpected = CNT_W'(DUTY_FORTY);         // static forty is in force out of reset
        rstN          = 1'b0;
        dutyMode      = MODE_STATIC_FORTY;

        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        fd = $fopen("verification/motorPwmTestdata.txt", "r");
        if (fd == 0) begin
            otherCount++;
            $display("Could not open the test data file verification/motorPwmTestdata.txt");
        end else begin
            waitForSync(spacing);                   // first frame after reset has no strobe
            lineNo = 0;
            while (!timedOut && !$feof(fd)) begin
                lineText = '0;
                if ($fgets(lineText, fd) != 0) begin
                    lineNo++;
                    if (!isCommentOrBlank(lineText)) begin
                        fields = $sscanf(lineText, "%d %d %d", lineMode, lineApply,
                                         lineExpected);
                        if (fields != 3) begin
                            otherCount++;
                            $display("Test data line %0d does not hold three numbers", lineNo);
                        end else begin
                            runLine(lineNo, MODE_W'(lineMode), lineApply != 0,
                                    CNT_W'(lineExpected));
                        end
                    end
                end
            end
            $fclose(fd);
        end

        if (linesChecked == 0) begin
            otherCount++;
            $display("No PWM period was checked");
        end

        $display("Checked %0d periods: %0d mismatches, %0d timeouts, %0d other errors",
                 linesChecked, mismatchCount, timeoutCount, otherCount);
        if (mismatchCount + timeoutCount + otherCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verification/motorPwmTestdata.txt
# columns: mode (0 static40, 1 ramp40, 2 ramp80, 3 full), apply now (1/0), expected high count
# an applied mode is driven right after periodSync and checked on the next full period
0 0 50
0 0 50
0 0 50
1 1 50
1 0 50
1 0 50
1 0 44
1 0 44
1 0 44
1 0 44
1 0 38
1 0 38
1 0 38
1 0 38
1 0 32
1 1 32
2 1 100
2 0 100
2 0 100
2 0 106
2 0 106
2 0 106
2 0 106
2 0 112
2 0 112
2 0 112
2 0 112
2 0 118
1 1 50
1 0 50
3 1 125
3 0 125
0 1 50
0 0 50
